/* sources.f */
+incdir+logic
logic/api_pkg.sv
logic/sync_fifo.sv
logic/api_bus_decode.sv
logic/api_ctrl_regs.sv
logic/work_counter.sv
logic/api_read_mux.sv
logic/miner_api_top.sv
sim/tb_miner_api.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the miner API testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f \
        --top-module tb_miner_api -o sim_miner_api
status=$?
if [ $status -ne 0 ]; then
        echo "Verilator build failed with status $status"
        exit 1
fi

./obj_dir/sim_miner_api
status=$?
if [ $status -ne 0 ]; then
        echo "Simulation ended with status $status"
        exit 1
fi

exit 0

/* sim/tb_miner_api.sv */
`timescale 1ns/1ps
`default_nettype none

`include "api_config.svh"

module tb_miner_api;
        import api_pkg::*;

        localparam int TIMEOUT_CYCLES = 50;
        localparam int TX_DEPTH       = 1 << `API_TX_DEPTH_LOG2;
        localparam int RX_DEPTH       = 1 << `API_RX_DEPTH_LOG2;

        logic        clk;
        logic        rst;
        logic        wb_stb;
        logic        wb_we;
        api_addr_t   wb_adr;
        api_word_t   wb_dat_i;
        logic        wb_ack;
        api_word_t   wb_dat_o;
        result_t     result_in;
        logic        tx_pop;
        api_word_t   tx_data;
        logic        tx_empty;
        logic [27:0] timeout;
        logic [7:0]  sck;
        logic [5:0]  ch_num;
        logic [7:0]  word_num;
        logic        flush;

        // Reference model state
        api_word_t   tx_q[$];
        api_word_t   rx_q[$];
        logic [27:0] m_timeout;
        api_word_t   m_sck_word;
        api_word_t   m_last;
        lw_count_t   m_cnt [`API_MINERS];
        lw_count_t   m_snap;
        api_word_t   rd_data;
        int          flush_seen;

        miner_api_top uut (
                .clk(clk), .rst(rst), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
                .wb_dat_i(wb_dat_i), .result_in(result_in), .tx_pop(tx_pop),
                .wb_ack(wb_ack), .wb_dat_o(wb_dat_o), .tx_data(tx_data),
                .tx_empty(tx_empty), .timeout(timeout), .sck(sck), .ch_num(ch_num),
                .word_num(word_num), .flush(flush)
        );

        always #50 clk = ~clk;

        always @(negedge clk) begin
                if (flush)
                        flush_seen++;   // Cycles with flush high
        end

        task automatic check_value(input string name, input api_word_t got,
                                   input api_word_t exp);
                if (got !== exp) begin
                        $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h",
                                 name, got, exp);
                        $display("Verification failed");
                        $fatal(1);
                end
        endtask

        task automatic stop_on_timeout(input string what);
                $display("Timed out waiting for %s", what);
                $display("Verification failed");
                $fatal(1);
        endtask

        //------------------------------------------------------------
        // Bus and stream drivers
        //------------------------------------------------------------
        task automatic bus_xfer(input logic we, input api_addr_t adr, input api_word_t data);
                int n;
                @(posedge clk);
                wb_stb   <= 1'b1;
                wb_we    <= we;
                wb_adr   <= adr;
                wb_dat_i <= data;
                n = 0;
                do begin
                        @(negedge clk);
                        n++;
                        if (n > TIMEOUT_CYCLES)
                                stop_on_timeout("the bus acknowledge");
                end while (!wb_ack);
                // First negedge still lies in the strobe cycle
                check_value("wb_ack latency", 32'(n - 1), 32'd1);
                rd_data = wb_dat_o;   // Valid while ack is high
                @(posedge clk);
                wb_stb <= 1'b0;
                wb_we  <= 1'b0;
                @(negedge clk);
                check_value("wb_ack", 32'(wb_ack), 32'h0);   // Single-cycle ack
        endtask

        task automatic check_config_outputs();
                check_value("timeout", 32'(timeout), 32'(m_timeout));
                check_value("sck", 32'(sck), 32'(m_sck_word[7:0]));
                check_value("ch_num", 32'(ch_num), 32'(m_sck_word[21:16]));
                check_value("word_num", 32'(word_num), 32'(m_sck_word[31:24]));
        endtask

        task automatic bus_write(input api_addr_t adr, input api_word_t data);
                int idx;
                bus_xfer(1'b1, adr, data);
                case (adr)
                `API_ADDR_TXFIFO:
                        if (tx_q.size() < TX_DEPTH)
                                tx_q.push_back(data);   // Full FIFO drops it
                `API_ADDR_TIMEOUT: m_timeout = data[27:0];
                `API_ADDR_SCK:     m_sck_word = data & 32'hFF3F_00FF;   // Unused bits read 0
                `API_ADDR_STATE:
                        if (data[1]) begin
                                tx_q.delete();
                                rx_q.delete();
                        end
                `API_ADDR_LW: begin
                        idx = (data[3:0] > 4'd9) ? (`API_MINERS - 1) : int'(data[3:0]);
                        m_snap = m_cnt[idx];
                        m_cnt[idx] = '0;
                end
                default: ;
                endcase
                check_config_outputs();
        endtask

        function automatic api_word_t status_model();
                api_word_t s;
                s        = '0;
                s[29:20] = 10'(rx_q.size());
                s[16]    = (rx_q.size() == 0);
                s[12:2]  = 11'(tx_q.size());
                s[0]     = (tx_q.size() == TX_DEPTH);
                return s;
        endfunction

        task automatic read_check(input api_addr_t adr, input string name);
                api_word_t exp;
                case (adr)
                `API_ADDR_RXFIFO:  exp = (rx_q.size() == 0) ? `API_EMPTY_WORD : rx_q[0];
                `API_ADDR_STATE:   exp = status_model();
                `API_ADDR_TIMEOUT: exp = {4'h0, m_timeout};
                `API_ADDR_SCK:     exp = m_sck_word;
                `API_ADDR_LW:      exp = api_word_t'(m_snap);
                default:           exp = `API_BAD_WORD;
                endcase
                bus_xfer(1'b0, adr, '0);
                check_value(name, rd_data, exp);
                if (adr == `API_ADDR_RXFIFO && rx_q.size() != 0)
                        void'(rx_q.pop_front());
        endtask

        task automatic send_result(input api_word_t word, input miner_id_t miner,
                                   input work_cnt_t wc);
                logic range_ok;
                @(posedge clk);
                result_in.valid    <= 1'b1;
                result_in.word     <= word;
                result_in.miner    <= miner;
                result_in.work_cnt <= wc;
                @(posedge clk);
                result_in.valid <= 1'b0;
                if (rx_q.size() < RX_DEPTH)
                        rx_q.push_back(word);
                range_ok = (wc >= 5'd2) && (wc <= 5'd9);
                if (range_ok && word != `API_MARKER_WORD && word != m_last &&
                    word != 32'h0 && word != 32'hFFFF_FFFF && miner < `API_MINERS)
                        m_cnt[miner] = m_cnt[miner] + lw_count_t'(1);
                if (range_ok)
                        m_last = word;
        endtask

        // Random beat with markers, repeats and all-zero/all-one words mixed in
        task automatic send_random_result(inout api_word_t prev);
                api_word_t w;
                case ($urandom_range(0, 5))
                0:       w = `API_MARKER_WORD;
                1:       w = prev;
                2:       w = 32'h0;
                3:       w = 32'hFFFF_FFFF;
                default: w = $urandom();
                endcase
                prev = w;
                send_result(w, miner_id_t'($urandom_range(0, 11)),
                            work_cnt_t'($urandom_range(0, 12)));
        endtask

        task automatic pop_tx_check();
                @(negedge clk);
                check_value("tx_empty", 32'(tx_empty), 32'(tx_q.size() == 0));
                if (tx_q.size() != 0) begin
                        check_value("tx_data", tx_data, tx_q[0]);
                        void'(tx_q.pop_front());
                end
                @(posedge clk);
                tx_pop <= 1'b1;
                @(posedge clk);
                tx_pop <= 1'b0;
        endtask

        //------------------------------------------------------------
        // Test sequence
        //------------------------------------------------------------
        initial begin
                api_word_t prev;
                int        n;
                void'($urandom(37));
                clk        = 1'b0;
                rst        = 1'b1;
                wb_stb     = 1'b0;
                wb_we      = 1'b0;
                wb_adr     = '0;
                wb_dat_i   = '0;
                result_in  = '0;
                tx_pop     = 1'b0;
                m_timeout  = '0;
                m_sck_word = '0;
                m_last     = '0;
                m_snap     = '0;
                prev       = '0;
                flush_seen = 0;
                for (int i = 0; i < `API_MINERS; i++)
                        m_cnt[i] = '0;
                repeat (8) @(posedge clk);
                rst <= 1'b0;

                // Config registers and unmapped space
                for (int i = 0; i < 40; i++) begin
                        case ($urandom_range(0, 4))
                        0: bus_write(`API_ADDR_TIMEOUT, $urandom());
                        1: bus_write(`API_ADDR_SCK, $urandom());
                        2: read_check(`API_ADDR_TIMEOUT, "wb_dat_o timeout");
                        3: read_check(`API_ADDR_SCK, "wb_dat_o sck");
                        default: begin
                                bus_write({4'($urandom()), 2'($urandom_range(1, 3))}, $urandom());
                                read_check({4'($urandom()), 2'($urandom_range(1, 3))},
                                           "wb_dat_o unmapped");
                        end
                        endcase
                end
                read_check(`API_ADDR_TXFIFO, "wb_dat_o txfifo");

                // TX FIFO past full, then random push/pop mix and drain
                for (int i = 0; i < 20; i++)
                        bus_write(`API_ADDR_TXFIFO, $urandom());
                read_check(`API_ADDR_STATE, "wb_dat_o status");
                for (int i = 0; i < 60; i++) begin
                        case ($urandom_range(0, 3))
                        0, 1: bus_write(`API_ADDR_TXFIFO, $urandom());
                        2:    pop_tx_check();
                        default: read_check(`API_ADDR_STATE, "wb_dat_o status");
                        endcase
                end
                for (int i = 0; i <= TX_DEPTH; i++)
                        pop_tx_check();

                // RX FIFO overflow, reads past empty, then mixed traffic
                for (int i = 0; i < 12; i++)
                        send_random_result(prev);
                read_check(`API_ADDR_STATE, "wb_dat_o status");
                for (int i = 0; i < 10; i++)
                        read_check(`API_ADDR_RXFIFO, "wb_dat_o rxfifo");
                for (int i = 0; i < 50; i++) begin
                        case ($urandom_range(0, 2))
                        0:       send_random_result(prev);
                        1:       read_check(`API_ADDR_RXFIFO, "wb_dat_o rxfifo");
                        default: read_check(`API_ADDR_STATE, "wb_dat_o status");
                        endcase
                end

                // Local work counting sampled per miner
                for (int round = 0; round < 3; round++) begin
                        for (int i = 0; i < 80; i++)
                                send_random_result(prev);
                        // Index above 9 samples the last miner
                        bus_write(`API_ADDR_LW, api_word_t'($urandom_range(10, 15)));
                        read_check(`API_ADDR_LW, "wb_dat_o lw");
                        for (int m = 0; m < `API_MINERS; m++) begin
                                bus_write(`API_ADDR_LW, api_word_t'(m));
                                read_check(`API_ADDR_LW, "wb_dat_o lw");
                        end
                end

                // Flush with both FIFOs loaded
                for (int i = 0; i < 5; i++) begin
                        bus_write(`API_ADDR_TXFIFO, $urandom());
                        send_random_result(prev);
                end
                flush_seen = 0;
                bus_write(`API_ADDR_STATE, 32'h2);
                n = 0;
                do begin
                        @(negedge clk);
                        n++;
                        if (n > TIMEOUT_CYCLES)
                                stop_on_timeout("the end of flush");
                end while (flush);
                check_value("flush cycles", 32'(flush_seen), 32'(`API_FLUSH_CYCLES));
                check_value("tx_empty", 32'(tx_empty), 32'h1);
                read_check(`API_ADDR_STATE, "wb_dat_o status");

                $display("Verification passed");
                $finish;
        end

endmodule

`default_nettype wire

/* logic/miner_api_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "api_config.svh"

module miner_api_top (
        input  wire logic              clk,
        input  wire logic              rst,
        input  wire logic              wb_stb,
        input  wire logic              wb_we,
        input  api_pkg::api_addr_t     wb_adr,
        input  api_pkg::api_word_t     wb_dat_i,
        input  api_pkg::result_t       result_in,
        input  wire logic              tx_pop,
        output logic                   wb_ack,
        output api_pkg::api_word_t     wb_dat_o,
        output api_pkg::api_word_t     tx_data,
        output logic                   tx_empty,
        output logic [27:0]            timeout,
        output logic [7:0]             sck,
        output logic [5:0]             ch_num,
        output logic [7:0]             word_num,
        output logic                   flush
);
        import api_pkg::*;

        api_req_t                      req;
        api_word_t                     rx_dout;
        logic                          rx_empty;
        logic [`API_RX_DEPTH_LOG2:0]   rx_level;
        logic [`API_TX_DEPTH_LOG2:0]   tx_level;
        logic                          tx_full;
        lw_count_t                     lw_snapshot;
        logic                          tx_push;
        logic                          rx_pop;

        assign tx_push = req.valid & req.we & req.sel[`API_SEL_TXFIFO];
        assign rx_pop  = req.valid & ~req.we & req.sel[`API_SEL_RXFIFO];

        //------------------------------------------------------------
        // Decode and execute
        //------------------------------------------------------------
        api_bus_decode u_decode (
                .clk(clk), .rst(rst), .wb_stb(wb_stb), .wb_we(wb_we),
                .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack), .req(req)
        );

        api_ctrl_regs u_ctrl_regs (
                .clk(clk), .rst(rst), .req(req), .timeout(timeout), .sck(sck),
                .ch_num(ch_num), .word_num(word_num), .flush(flush)
        );

        work_counter u_work_counter (
                .clk(clk), .rst(rst), .req(req), .result_in(result_in),
                .lw_snapshot(lw_snapshot)
        );

        //------------------------------------------------------------
        // FIFOs
        //------------------------------------------------------------
        sync_fifo #(.DEPTH_LOG2(`API_TX_DEPTH_LOG2), .WIDTH(32)) tx_fifo (
                .clk(clk), .rst(rst), .flush(flush), .push(tx_push), .din(req.data),
                .pop(tx_pop), .dout(tx_data), .level(tx_level), .full(tx_full),
                .empty(tx_empty)
        );

        // Results beyond the RX depth are dropped
        sync_fifo #(.DEPTH_LOG2(`API_RX_DEPTH_LOG2), .WIDTH(32)) rx_fifo (
                .clk(clk), .rst(rst), .flush(flush), .push(result_in.valid),
                .din(result_in.word), .pop(rx_pop), .dout(rx_dout), .level(rx_level),
                .full(), .empty(rx_empty)
        );

        api_read_mux u_read_mux (
                .clk(clk), .rst(rst), .req(req), .rx_dout(rx_dout), .rx_empty(rx_empty),
                .rx_level(rx_level), .tx_level(tx_level), .tx_full(tx_full),
                .flush(flush), .timeout(timeout), .sck(sck), .ch_num(ch_num),
                .word_num(word_num), .lw_snapshot(lw_snapshot), .wb_dat_o(wb_dat_o)
        );

endmodule

`default_nettype wire

/* logic/api_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "api_config.svh"

module api_read_mux (
        input  wire logic                          clk,
        input  wire logic                          rst,
        input  api_pkg::api_req_t                  req,
        input  api_pkg::api_word_t                 rx_dout,
        input  wire logic                          rx_empty,
        input  wire logic [`API_RX_DEPTH_LOG2:0]   rx_level,
        input  wire logic [`API_TX_DEPTH_LOG2:0]   tx_level,
        input  wire logic                          tx_full,
        input  wire logic                          flush,
        input  wire logic [27:0]                   timeout,
        input  wire logic [7:0]                    sck,
        input  wire logic [5:0]                    ch_num,
        input  wire logic [7:0]                    word_num,
        input  api_pkg::lw_count_t                 lw_snapshot,
        output api_pkg::api_word_t                 wb_dat_o
);
        import api_pkg::*;

        api_word_t status_word;
        api_word_t sck_word;
        logic      rd;

        assign rd = req.valid & ~req.we;

        // Bits 15:13 and 19:17 are reserved and read as zero
        assign status_word = {2'b00, 10'(rx_level), 3'b000, rx_empty,
                              3'b000, 11'(tx_level), flush, tx_full};

        assign sck_word = {word_num, 2'b00, ch_num, 8'h00, sck};

        //------------------------------------------------------------
        // Read data register
        //------------------------------------------------------------
        always_ff @(posedge clk or posedge rst) begin
                if (rst)
                        wb_dat_o <= '0;
                else if (rd) begin
                        if (req.sel[`API_SEL_STATE])
                                wb_dat_o <= status_word;
                        else if (req.sel[`API_SEL_RXFIFO])
                                wb_dat_o <= rx_empty ? `API_EMPTY_WORD : rx_dout;
                        else if (req.sel[`API_SEL_TIMEOUT])
                                wb_dat_o <= {4'h0, timeout};
                        else if (req.sel[`API_SEL_SCK])
                                wb_dat_o <= sck_word;
                        else if (req.sel[`API_SEL_LW])
                                wb_dat_o <= api_word_t'(lw_snapshot);
                        else
                                wb_dat_o <= `API_BAD_WORD;   // TX FIFO or unmapped
                end
        end

endmodule

`default_nettype wire

/* logic/work_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "api_config.svh"

module work_counter (
        input  wire logic              clk,
        input  wire logic              rst,
        input  api_pkg::api_req_t      req,
        input  api_pkg::result_t       result_in,
        output api_pkg::lw_count_t     lw_snapshot
);
        import api_pkg::*;

        lw_count_t  cnt [`API_MINERS];
        api_word_t  last_word;     // Last word with an in-range work count
        logic       range_ok;
        logic       count_ok;
        logic       sample;
        miner_id_t  sample_idx;

        //------------------------------------------------------------
        // Result filter
        //------------------------------------------------------------
        assign range_ok = result_in.valid &&
                          (result_in.work_cnt >= 5'd2) &&
                          (result_in.work_cnt <= 5'd9);

        assign count_ok = range_ok &&
                          (result_in.word != `API_MARKER_WORD) &&
                          (result_in.word != last_word) &&   // Repeat
                          (|result_in.word) &&                // All zeros
                          (|(~result_in.word));               // All ones

        always_ff @(posedge clk or posedge rst) begin
                if (rst)
                        last_word <= '0;
                else if (range_ok)
                        last_word <= result_in.word;
        end

        //------------------------------------------------------------
        // Counters and sample-and-clear
        //------------------------------------------------------------
        assign sample     = req.valid & req.we & req.sel[`API_SEL_LW];
        assign sample_idx = (req.data[3:0] > miner_id_t'(`API_MINERS - 1)) ?
                            miner_id_t'(`API_MINERS - 1) : req.data[3:0];   // Clamp

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        for (int i = 0; i < `API_MINERS; i++)
                                cnt[i] <= '0;
                        lw_snapshot <= '0;
                end else begin
                        if (sample)
                                lw_snapshot <= cnt[sample_idx];
                        for (int i = 0; i < `API_MINERS; i++) begin
                                if (sample && sample_idx == miner_id_t'(i))
                                        cnt[i] <= '0;   // Clear wins over a count
                                else if (count_ok && result_in.miner == miner_id_t'(i))
                                        cnt[i] <= cnt[i] + lw_count_t'(1);   // Wraps
                        end
                end
        end

endmodule

`default_nettype wire

/* logic/api_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "api_config.svh"

module api_ctrl_regs (
        input  wire logic              clk,
        input  wire logic              rst,
        input  api_pkg::api_req_t      req,
        output logic [27:0]            timeout,
        output logic [7:0]             sck,
        output logic [5:0]             ch_num,
        output logic [7:0]             word_num,
        output logic                   flush
);

        logic                          wr_timeout;
        logic                          wr_sck;
        logic                          wr_state;
        logic [`API_FLUSH_CYCLES-1:0]  flush_sr;

        assign wr_timeout = req.valid & req.we & req.sel[`API_SEL_TIMEOUT];
        assign wr_sck     = req.valid & req.we & req.sel[`API_SEL_SCK];
        assign wr_state   = req.valid & req.we & req.sel[`API_SEL_STATE];

        //------------------------------------------------------------
        // Timeout and serial clock / channel config
        //------------------------------------------------------------
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        timeout  <= '0;
                        sck      <= '0;
                        ch_num   <= '0;
                        word_num <= '0;
                end else begin
                        if (wr_timeout)
                                timeout <= req.data[27:0];
                        if (wr_sck) begin
                                sck      <= req.data[7:0];
                                ch_num   <= req.data[21:16];   // Bits 15:8 unused
                                word_num <= req.data[31:24];
                        end
                end
        end

        //------------------------------------------------------------
        // Flush pulse
        //------------------------------------------------------------
        // A single bit walks through the shift register, so the OR of
        // all stages stays high for API_FLUSH_CYCLES cycles
        always_ff @(posedge clk or posedge rst) begin
                if (rst)
                        flush_sr <= '0;
                else if (wr_state)
                        flush_sr <= {{(`API_FLUSH_CYCLES-1){1'b0}}, req.data[1]};
                else
                        flush_sr <= flush_sr << 1;
        end

        assign flush = |flush_sr;

endmodule

`default_nettype wire

/* logic/api_bus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "api_config.svh"

module api_bus_decode (
        input  wire logic              clk,
        input  wire logic              rst,
        input  wire logic              wb_stb,
        input  wire logic              wb_we,
        input  api_pkg::api_addr_t     wb_adr,
        input  api_pkg::api_word_t     wb_dat_i,
        output logic                   wb_ack,
        output api_pkg::api_req_t      req
);
        import api_pkg::*;

        api_sel_t sel;
        logic     start;

        // First cycle of a strobe not yet acknowledged
        assign start = wb_stb & ~wb_ack;

        //------------------------------------------------------------
        // Acknowledge
        //------------------------------------------------------------
        always_ff @(posedge clk or posedge rst) begin
                if (rst)
                        wb_ack <= 1'b0;
                else
                        wb_ack <= start;   // High for exactly one cycle
        end

        //------------------------------------------------------------
        // Address decode
        //------------------------------------------------------------
        always_comb begin
                sel = '0;
                sel[`API_SEL_TXFIFO]  = (wb_adr == `API_ADDR_TXFIFO);
                sel[`API_SEL_RXFIFO]  = (wb_adr == `API_ADDR_RXFIFO);
                sel[`API_SEL_STATE]   = (wb_adr == `API_ADDR_STATE);
                sel[`API_SEL_TIMEOUT] = (wb_adr == `API_ADDR_TIMEOUT);
                sel[`API_SEL_SCK]     = (wb_adr == `API_ADDR_SCK);
                sel[`API_SEL_LW]      = (wb_adr == `API_ADDR_LW);
        end

        // Unmapped address still gives a valid request with no select bit
        always_comb begin
                req.valid = start;
                req.we    = wb_we;
                req.sel   = sel;
                req.data  = wb_dat_i;
        end

endmodule

`default_nettype wire

/* logic/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
        parameter int DEPTH_LOG2 = 4,
        parameter int WIDTH      = 32
) (
        input  wire logic                  clk,
        input  wire logic                  rst,
        input  wire logic                  flush,
        input  wire logic                  push,
        input  wire logic [WIDTH-1:0]      din,
        input  wire logic                  pop,
        output logic      [WIDTH-1:0]      dout,
        output logic      [DEPTH_LOG2:0]   level,
        output logic                       full,
        output logic                       empty
);

        localparam int DEPTH = 1 << DEPTH_LOG2;

        logic [WIDTH-1:0]    mem [DEPTH];
        logic [DEPTH_LOG2:0] wr_ptr;   // Extra bit tells full from empty
        logic [DEPTH_LOG2:0] rd_ptr;
        logic                do_push;
        logic                do_pop;

        assign do_push = push & ~full;
        assign do_pop  = pop & ~empty;

        //------------------------------------------------------------
        // Pointers
        //------------------------------------------------------------
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else if (flush) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        if (do_push)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (do_pop)
                                rd_ptr <= rd_ptr + 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (do_push && !flush)
                        mem[wr_ptr[DEPTH_LOG2-1:0]] <= din;
        end

        assign level = wr_ptr - rd_ptr;
        assign empty = (wr_ptr == rd_ptr);
        assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                       (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

        // Head word falls through and reads zero while empty
        assign dout = empty ? '0 : mem[rd_ptr[DEPTH_LOG2-1:0]];

endmodule

`default_nettype wire

/* logic/api_pkg.sv */
`default_nettype none

`include "api_config.svh"

package api_pkg;

        typedef logic [31:0]                   api_word_t;
        typedef logic [5:0]                    api_addr_t;
        typedef logic [`API_SEL_COUNT-1:0]     api_sel_t;   // One-hot or all zero if unmapped
        typedef logic [`API_LW_WIDTH-1:0]      lw_count_t;
        typedef logic [3:0]                    miner_id_t;
        typedef logic [4:0]                    work_cnt_t;

        // One bus request, valid for a single cycle
        typedef struct packed {
                logic      valid;
                logic      we;
                api_sel_t  sel;
                api_word_t data;
        } api_req_t;

        // One result beat from the chips
        typedef struct packed {
                logic      valid;
                api_word_t word;
                miner_id_t miner;
                work_cnt_t work_cnt;
        } result_t;

endpackage

`default_nettype wire

/* logic/api_config.svh */
`ifndef API_CONFIG_SVH
`define API_CONFIG_SVH

// Register offsets on the host bus
`define API_ADDR_TXFIFO   6'h00
`define API_ADDR_RXFIFO   6'h04
`define API_ADDR_STATE    6'h08
`define API_ADDR_TIMEOUT  6'h0C
`define API_ADDR_SCK      6'h10
`define API_ADDR_LW       6'h18

// Bit positions in the one-hot register select
`define API_SEL_TXFIFO    0
`define API_SEL_RXFIFO    1
`define API_SEL_STATE     2
`define API_SEL_TIMEOUT   3
`define API_SEL_SCK       4
`define API_SEL_LW        5
`define API_SEL_COUNT     6

`define API_TX_DEPTH_LOG2 4
`define API_RX_DEPTH_LOG2 3

`define API_MINERS        10
`define API_LW_WIDTH      24

`define API_MARKER_WORD   32'hBEAF_BEAF   // Filler from the chips
`define API_EMPTY_WORD    32'h1234_5678   // Read of an empty RX FIFO
`define API_BAD_WORD      32'hDEAD_DEAD   // Unmapped or write-only

`define API_FLUSH_CYCLES  4

`endif
